// File: logic/cache_pkg.sv
package cache_pkg;

	localparam int ADDR_W  = 16;            // byte address width
	localparam int DATA_W  = 16;            // pipeline word width
	localparam int TAG_W   = 5;             // tag bits at the top of the address
	localparam int INDEX_W = 7;             // set index bits
	localparam int WORDS   = 8;             // words per block
	localparam int SETS    = 1 << INDEX_W;  // one block per set, 128 sets
	localparam int WORD_W  = $clog2(WORDS); // word index inside a block

	typedef logic [DATA_W-1:0] data_t; // one cached word

	// addr : tttt tsss ssss wwwb
	typedef struct packed {
		logic [TAG_W-1:0]   tag;      // compared against the stored tag
		logic [INDEX_W-1:0] index;    // selects the set
		logic [WORD_W-1:0]  word;     // selects the word in the block
		logic               byte_sel; // ignored, word accesses only
	} cache_addr_t;

	typedef struct packed {
		logic             valid; // block holds memory data
		logic [TAG_W-1:0] tag;   // tag of the resident block
	} meta_t;

	typedef struct packed {
		logic        read;  // pipeline load
		logic        write; // pipeline store, never together with read
		cache_addr_t addr;  // byte address of the access
		data_t       wdata; // store data
	} cache_req_t;

	typedef struct packed {
		logic              read;  // level, held for the whole fill
		logic              write; // one cycle per store
		logic [ADDR_W-1:0] addr;  // fill address or store address
		data_t             wdata; // store data, write through
	} mem_req_t;

	typedef struct packed {
		logic              busy;    // fill in progress
		logic [WORD_W-1:0] word;    // word being fetched
		logic              word_we; // memory word arrived this cycle
		logic              tag_we;  // last word, tag goes in now
	} fill_ctl_t;

endpackage

// File: logic/cache_bank.sv
module cache_bank #(
	parameter type entry_t = cache_pkg::data_t, // payload stored per set
	parameter int  DEPTH   = cache_pkg::SETS    // entries, one per set
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     we,     // write strobe
	input  logic [$clog2(DEPTH)-1:0] windex, // write set
	input  entry_t                   wentry, // write payload
	input  logic [$clog2(DEPTH)-1:0] rindex, // read set
	output entry_t                   rentry  // read payload, combinational
);

	entry_t mem [DEPTH]; // one entry per set

	// whole array cleared on reset so valid bits start low
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0; // every set empty
			end
		end else if (we) begin
			mem[windex] <= wentry; // single write port
		end
	end

	assign rentry = mem[rindex]; // async read, same cycle as lookup

endmodule

// File: logic/cache_lookup.sv
module cache_lookup (
	input  cache_pkg::cache_req_t                 req,        // held pipeline request
	input  cache_pkg::fill_ctl_t                  fill,       // fill controller state
	input  logic [cache_pkg::DATA_W-1:0]          mem_rdata,  // word coming back from memory
	input  cache_pkg::meta_t                      meta,       // stored tag of the indexed set
	output logic [cache_pkg::INDEX_W-1:0]         index,      // set for all banks
	output logic [cache_pkg::WORD_W-1:0]          word,       // addressed word
	output logic                                  hit,
	output logic                                  miss,
	output logic [cache_pkg::WORDS-1:0]           word_we,    // one strobe per word bank
	output logic [cache_pkg::DATA_W-1:0]          word_wdata, // shared by all word banks
	output logic                                  meta_we,    // tag write at end of fill
	output cache_pkg::meta_t                      meta_new    // entry written on fill
);

	import cache_pkg::*;

	logic req_valid; // pipeline wants something
	logic tag_match; // resident block is the addressed one

	assign req_valid = req.read | req.write;
	assign index     = req.addr.index; // request is held during fill, same set
	assign word      = req.addr.word;

	assign tag_match = meta.valid && (meta.tag == req.addr.tag);

	// no lookups while the fill owns the banks
	assign hit  = req_valid & tag_match & ~fill.busy;
	assign miss = req_valid & ~tag_match & ~fill.busy;

	always_comb begin
		word_we    = '0;
		word_wdata = req.wdata;              // store data by default
		if (fill.busy) begin
			word_we[fill.word] = fill.word_we; // memory word lands in its bank
			word_wdata         = mem_rdata;
		end else begin
			word_we[req.addr.word] = hit & req.write; // store hit
		end
	end

	assign meta_we        = fill.tag_we;  // only the fill allocates
	assign meta_new.valid = 1'b1;
	assign meta_new.tag   = req.addr.tag; // tag of the block being filled

endmodule

// File: logic/cache_fill_fsm.sv
module cache_fill_fsm (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         miss,           // lookup saw a miss
	input  cache_pkg::cache_addr_t       miss_addr,      // address that missed
	input  logic                         mem_data_valid, // one strobe per word
	output cache_pkg::fill_ctl_t         fill,           // state for lookup and word select
	output logic [cache_pkg::ADDR_W-1:0] fill_addr,      // memory read address
	output logic                         finish          // one cycle, last word
);

	import cache_pkg::*;

	typedef enum logic {
		IDLE,
		FILLING
	} state_t;

	state_t             state;
	state_t             state_nxt;
	logic [WORD_W-1:0]  count;      // next word to fetch
	logic [TAG_W-1:0]   base_tag;   // block being filled
	logic [INDEX_W-1:0] base_index;
	logic               start;      // miss accepted this cycle
	logic               last_word;  // count points at final word
	cache_addr_t        fill_ptr;

	assign start     = (state == IDLE) & miss;
	assign last_word = (count == WORD_W'(WORDS - 1));

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_nxt = FILLING; // busy rises at this edge
				end
			end
			FILLING: begin
				if (mem_data_valid && last_word) begin
					state_nxt = IDLE; // eighth word in, tag goes with it
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			count <= '0;
		end else begin
			state <= state_nxt;
			if (start) begin
				count <= '0;         // fill starts at word 0
			end else if (fill.word_we) begin
				count <= count + 1'b1; // wraps back to 0 after the last word
			end
		end
	end

	// block base, only meaningful while filling
	always_ff @(posedge clk) begin
		if (start) begin
			base_tag   <= miss_addr.tag;
			base_index <= miss_addr.index;
		end
	end

	assign fill.busy    = (state == FILLING);
	assign fill.word    = count;
	assign fill.word_we = fill.busy & mem_data_valid; // latency set by memory
	assign fill.tag_we  = fill.word_we & last_word;
	assign finish       = fill.tag_we; // high while busy falls

	assign fill_ptr.tag      = base_tag;
	assign fill_ptr.index    = base_index;
	assign fill_ptr.word     = count;
	assign fill_ptr.byte_sel = 1'b0; // word aligned
	assign fill_addr         = fill_ptr;

endmodule

// File: logic/cache_word_select.sv
module cache_word_select (
	input  logic [cache_pkg::WORDS-1:0][cache_pkg::DATA_W-1:0] words,     // one word per bank
	input  logic [cache_pkg::WORD_W-1:0]                       word,      // addressed word
	input  cache_pkg::cache_req_t                              req,       // held request
	input  logic                                               hit,       // lookup hit
	input  cache_pkg::fill_ctl_t                               fill,      // fill state
	input  logic [cache_pkg::ADDR_W-1:0]                       fill_addr, // block base plus count
	output logic [cache_pkg::DATA_W-1:0]                       data_out,  // read data to pipeline
	output cache_pkg::mem_req_t                                mem_req    // memory side request
);

	import cache_pkg::*;

	logic store_hit; // write goes through to memory once

	assign data_out = words[word]; // valid on a read hit, same cycle

	assign store_hit = hit & req.write;

	always_comb begin
		mem_req.read  = fill.busy;  // level for the whole fill
		mem_req.write = store_hit;  // hit cycle only
		mem_req.wdata = req.wdata;
		if (fill.busy) begin
			mem_req.addr = fill_addr;
		end else begin
			mem_req.addr = req.addr; // store address when writing
		end
	end

endmodule

// File: logic/cache_top.sv
module cache_top (
	input  logic                         clk,
	input  logic                         arst_n,
	input  cache_pkg::cache_req_t        req,            // pipeline request, held until hit
	input  logic                         mem_data_valid, // memory word strobe
	input  logic [cache_pkg::DATA_W-1:0] mem_rdata,      // memory word
	output cache_pkg::mem_req_t          mem_req,        // to memory
	output logic [cache_pkg::DATA_W-1:0] cache_data_out, // read data
	output logic                         cache_hit,
	output logic                         cache_busy,     // fill in progress
	output logic                         cache_finish    // fill done pulse
);

	import cache_pkg::*;

	logic [INDEX_W-1:0]           index;
	logic [WORD_W-1:0]            word;
	logic                         miss;
	logic [WORDS-1:0]             word_we;
	data_t                        word_wdata;
	logic                         meta_we;
	meta_t                        meta_new;
	meta_t                        meta;       // stored entry of the indexed set
	fill_ctl_t                    fill;
	logic [ADDR_W-1:0]            fill_addr;
	logic [WORDS-1:0][DATA_W-1:0] words;      // bank outputs

	cache_lookup u_lookup (
		.req        (req),
		.fill       (fill),
		.mem_rdata  (mem_rdata),
		.meta       (meta),
		.index      (index),
		.word       (word),
		.hit        (cache_hit),
		.miss       (miss),
		.word_we    (word_we),
		.word_wdata (word_wdata),
		.meta_we    (meta_we),
		.meta_new   (meta_new)
	);

	cache_fill_fsm u_fill (
		.clk            (clk),
		.arst_n         (arst_n),
		.miss           (miss),
		.miss_addr      (req.addr),
		.mem_data_valid (mem_data_valid),
		.fill           (fill),
		.fill_addr      (fill_addr),
		.finish         (cache_finish)
	);

	cache_bank #(.entry_t(meta_t), .DEPTH(SETS)) u_meta ( // valid and tag per set
		.clk    (clk),
		.arst_n (arst_n),
		.we     (meta_we),
		.windex (index),
		.wentry (meta_new),
		.rindex (index),
		.rentry (meta)
	);

	for (genvar w = 0; w < WORDS; w++) begin : g_word
		cache_bank #(.entry_t(data_t), .DEPTH(SETS)) u_bank ( // word w of every block
			.clk    (clk),
			.arst_n (arst_n),
			.we     (word_we[w]),
			.windex (index),
			.wentry (word_wdata),
			.rindex (index),
			.rentry (words[w])
		);
	end

	cache_word_select u_select (
		.words     (words),
		.word      (word),
		.req       (req),
		.hit       (cache_hit),
		.fill      (fill),
		.fill_addr (fill_addr),
		.data_out  (cache_data_out),
		.mem_req   (mem_req)
	);

	assign cache_busy = fill.busy;

endmodule

// File: verification/cache_chk.sv
module cache_chk (
	input logic                clk,
	input logic                arst_n,
	input logic                cache_hit,
	input logic                cache_busy,
	input logic                cache_finish,
	input cache_pkg::mem_req_t mem_req
);

	timeunit 1ns;
	timeprecision 100ps;

	// finish only on the last fill cycle
	a_finish_busy: assert property (@(posedge clk) disable iff (!arst_n)
		cache_finish |-> cache_busy)
		else $error("finish seen while the cache was not busy");

	a_finish_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		cache_finish |=> (!cache_finish && !cache_busy))
		else $error("finish longer than one cycle or busy still high after it");

	a_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(cache_busy) |-> $past(cache_finish))
		else $error("busy fell without a finish pulse");

	a_read_busy: assert property (@(posedge clk) disable iff (!arst_n)
		mem_req.read |-> cache_busy) // fill reads only
		else $error("memory read outside a fill");

	a_write_idle: assert property (@(posedge clk) disable iff (!arst_n)
		cache_busy |-> !mem_req.write) // stores wait for the fill
		else $error("memory write during a fill");

	a_hit_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!(cache_hit && cache_busy))
		else $error("hit reported while busy");

endmodule

// File: verification/cache_tb.sv
module cache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import cache_pkg::*;

	localparam int    PERIOD    = 20;                 // clock period in ns
	localparam int    SEED      = 15218;
	localparam int    MEM_WORDS = 1 << (ADDR_W - 1);  // whole byte space in words
	localparam string VEC_FILE  = "verification/cache_vectors.txt";

	typedef struct packed {
		logic        write;    // store when set, load otherwise
		cache_addr_t addr;
		data_t       wdata;
		data_t       expected; // load data, the stored word for writes
	} vector_t;

	logic       clk;
	logic       arst_n;
	cache_req_t req;
	logic       mem_data_valid;
	data_t      mem_rdata;
	mem_req_t   mem_req;
	data_t      cache_data_out;
	logic       cache_hit;
	logic       cache_busy;
	logic       cache_finish;

	vector_t vectors[$];           // whole file, loaded before reset
	bit      vectors_loaded;       // starts the watchdog
	data_t   mem_model[MEM_WORDS];
	meta_t   resident[SETS];       // block each set should hold
	int      fills_total;          // read strobes since start
	int      writes_total;         // memory writes since reset

	cache_top uut (
		.clk            (clk),
		.arst_n         (arst_n),
		.req            (req),
		.mem_data_valid (mem_data_valid),
		.mem_rdata      (mem_rdata),
		.mem_req        (mem_req),
		.cache_data_out (cache_data_out),
		.cache_hit      (cache_hit),
		.cache_busy     (cache_busy),
		.cache_finish   (cache_finish)
	);

	bind cache_top cache_chk u_chk (
		.clk          (clk),
		.arst_n       (arst_n),
		.cache_hit    (cache_hit),
		.cache_busy   (cache_busy),
		.cache_finish (cache_finish),
		.mem_req      (mem_req)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic report_fail();
		$display("Verification failed");
		$fatal(1, "simulation stopped at %0t ns", $time);
	endtask

	task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			report_fail();
		end
	endtask

	task automatic load_vectors();
		int                fd;
		int                c;
		logic [ADDR_W-1:0] a;
		data_t             wd;
		data_t             ex;
		vector_t           v;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the vector file %s", VEC_FILE);
			report_fail();
		end
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == int'("#")) begin
				while (c != -1 && c != int'("\n")) c = $fgetc(fd); // skip comment line
			end else if (c == int'("r") || c == int'("w")) begin
				if ($fscanf(fd, "%h %h %h", a, wd, ex) != 3) begin
					$display("malformed line in the vector file after %0d vectors", vectors.size());
					report_fail();
				end
				v.write    = (c == int'("w"));
				v.addr     = a;
				v.wdata    = wd;
				v.expected = ex;
				vectors.push_back(v);
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
		if (vectors.size() == 0) begin
			$display("the vector file holds no vectors");
			report_fail();
		end
		vectors_loaded = 1'b1;
	endtask

	// one access, held until hit with busy low
	task automatic run_access(input vector_t v);
		meta_t    slot;
		logic     exp_miss;
		logic     saw_busy;
		int       finishes;
		int       fills_start;
		int       writes_start;
		mem_req_t exp_req;
		slot     = resident[v.addr.index];
		exp_miss = !(slot.valid && (slot.tag == v.addr.tag)); // direct mapped
		saw_busy = 1'b0;
		finishes = 0;
		@(negedge clk);
		fills_start  = fills_total;
		writes_start = writes_total;
		req.read     = !v.write;
		req.write    = v.write;
		req.addr     = v.addr;
		req.wdata    = v.write ? v.wdata : '0;
		#(PERIOD / 4);
		check_flag("cache_hit", cache_hit, !exp_miss); // first cycle decides
		while (!(cache_hit && !cache_busy)) begin
			@(negedge clk);
			#(PERIOD / 4);
			saw_busy = saw_busy | cache_busy;
			if (cache_finish) finishes++;
		end
		if (v.write) begin
			exp_req.read  = 1'b0;
			exp_req.write = 1'b1; // write through on the hit cycle
			exp_req.addr  = v.addr;
			exp_req.wdata = v.wdata;
			check_mem_req("mem_req", mem_req, exp_req);
		end else begin
			check_data("cache_data_out", cache_data_out, v.expected);
			check_data("memory model word", mem_model[v.addr[ADDR_W-1:1]], v.expected);
		end
		@(posedge clk);  // store lands here
		@(negedge clk);
		req = '0;
		check_flag("cache_busy seen", saw_busy, exp_miss);
		check_count("fill words", fills_total - fills_start, exp_miss ? WORDS : 0);
		check_count("finish pulses", finishes, exp_miss ? 1 : 0);
		check_count("memory writes", writes_total - writes_start, v.write ? 1 : 0);
		resident[v.addr.index].valid = 1'b1;
		resident[v.addr.index].tag   = v.addr.tag;
	endtask

	// memory read side, one strobe per word after 1 to 4 cycles
	initial begin
		int                wait_left;
		logic [WORD_W-1:0] fill_word;
		cache_addr_t       fill_exp;
		mem_req_t          exp_req;
		void'($urandom(SEED));
		mem_data_valid = 1'b0;
		mem_rdata      = '0;
		fills_total    = 0;
		wait_left      = -1;
		fill_word      = '0;
		forever begin
			@(negedge clk);
			if (!arst_n) begin
				mem_data_valid = 1'b0;
				wait_left      = -1;
				fill_word      = '0;
			end else if (mem_data_valid) begin
				mem_data_valid = 1'b0; // strobe lasts one cycle
			end else if (mem_req.read) begin
				if (wait_left < 0) wait_left = $urandom_range(0, 3);
				if (wait_left == 0) begin
					fill_exp          = req.addr;
					fill_exp.word     = fill_word; // consecutive words of the block
					fill_exp.byte_sel = 1'b0;
					exp_req.read      = 1'b1;
					exp_req.write     = 1'b0;
					exp_req.addr      = fill_exp;
					exp_req.wdata     = req.wdata;
					check_mem_req("mem_req", mem_req, exp_req);
					mem_rdata      = mem_model[mem_req.addr[ADDR_W-1:1]];
					mem_data_valid = 1'b1;
					fill_word      = fill_word + 1'b1;
					fills_total++;
					wait_left = -1;
				end else begin
					wait_left--;
				end
			end else begin
				fill_word = '0; // no fill running
				wait_left = -1;
			end
		end
	end

	// memory write side, content a ^ 5a5a at byte address a
	always @(posedge clk) begin
		if (!arst_n) begin
			writes_total <= 0;
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem_model[i] <= data_t'({i[ADDR_W-2:0], 1'b0}) ^ 16'h5a5a;
			end
		end else if (mem_req.write) begin
			mem_model[mem_req.addr[ADDR_W-1:1]] <= mem_req.wdata;
			writes_total                        <= writes_total + 1;
		end
	end

	initial begin
		wait (vectors_loaded);
		#(vectors.size() * WORDS * 6 * PERIOD + 50 * PERIOD); // slowest fill plus reset
		$display("timeout, the DUT did not finish the vectors in time");
		report_fail();
	end

	initial begin
		arst_n = 1'b0;
		req    = '0;
		foreach (resident[i]) resident[i] = '0;
		load_vectors();
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		#(PERIOD / 4);
		check_flag("cache_busy", cache_busy, 1'b0);
		check_flag("cache_finish", cache_finish, 1'b0);
		check_mem_req("mem_req", mem_req, '0); // no read, no write
		foreach (vectors[i]) begin
			run_access(vectors[i]);
		end
		$display("Verification passed");
		$finish;
	end

endmodule

// File: verification/cache_vectors.txt
# op address wdata expected
# r is a read and w a write with hex fields, reads carry wdata 0000
r 0100 0000 5b5a
r 0102 0000 5b58
r 010e 0000 5b54
r 0101 0000 5b5a
w 0104 1234 1234
r 0104 0000 1234
r 0106 0000 5b5c
w 0104 4321 4321
r 0104 0000 4321
w 0224 abcd abcd
r 0224 0000 abcd
r 0220 0000 587a
r 0222 0000 5878
r 0226 0000 587c
r 022e 0000 5874
r 0300 0000 595a
r 0b00 0000 515a
r 0302 0000 5958
r 0b02 0000 5158
r 0300 0000 595a
r 0b00 0000 515a
w 0b06 7777 7777
r 0300 0000 595a
r 0b06 0000 7777
r 0b04 0000 515e
r f7f0 0000 adaa
r f7fe 0000 ada4
w f7f8 0000 0000
r 07f0 0000 5daa
r f7f8 0000 0000
r f7fa 0000 ada0
w 07f2 5555 5555
r 07f2 0000 5555
r 07f0 0000 5daa
r 07f4 0000 5dae
r 0100 0000 5b5a
r 0104 0000 4321

// File: dm_cache.f
logic/cache_pkg.sv
logic/cache_bank.sv
logic/cache_lookup.sv
logic/cache_fill_fsm.sv
logic/cache_word_select.sv
logic/cache_top.sv
verification/cache_chk.sv
verification/cache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cache_tb \
	-f dm_cache.f -o cache_sim \
	&& ./obj_dir/cache_sim | tee /dev/stderr | grep -q "Verification passed" \
	&& echo "run_sim: simulation PASS" \
	|| { echo "run_sim: simulation FAIL"; exit 1; }
